// ==== include/mmio_defines.svh ====
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// Packet sizes on the two bulk pipes, fixed by the command protocol

// Command, byte 0 holds tag and code
// then 3 address bytes and 2 value bytes, LSB first
`define MMIO_CMD_BYTES 6

// Response, byte 0 holds tag, err and code
// then 2 value bytes, LSB first
`define MMIO_RSP_BYTES 3

// Identifier returned by QUERY
`define MMIO_DEVICE_ID 16'hB51C

`endif

// ==== src/mmio_pkg.sv ====
package mmio_pkg;

  // Low two bits of command byte 0
  typedef enum logic [1:0] {
    GET   = 2'd0,  // APB read
    SET   = 2'd1,  // APB write
    READY = 2'd2,  // Count of completed commands
    QUERY = 2'd3   // Device identifier
  } cmd_code_e;

  // Decoded command, as assembled by the Bulk-Out endpoint
  typedef struct packed {
    cmd_code_e   code;
    logic [3:0]  tag;
    logic [23:0] addr;
    logic [15:0] value;
  } mmio_cmd_t;

  // Response, serialized by the Bulk-In endpoint
  typedef struct packed {
    logic [3:0]  tag;    // Echoed from the command
    logic [1:0]  code;   // Echoed from the command
    logic        err;    // APB slave error
    logic [15:0] value;
  } mmio_rsp_t;

  // One byte beat of a bulk stream
  typedef struct packed {
    logic [7:0] tdata;
    logic       tkeep;
    logic       tlast;
  } usb_beat_t;

  // APB requester side
  typedef struct packed {
    logic [23:0] paddr;
    logic        pwrite;
    logic        penable;
    logic        psel;
    logic [1:0]  pstrb;
    logic [15:0] pwdata;
  } apb_req_t;

  // APB target side
  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [15:0] prdata;
  } apb_rsp_t;

endpackage

// ==== src/mmio_ep_out.sv ====
`timescale 1ns/1ps
`include "mmio_defines.svh"

// Bulk-Out endpoint, assembles one command packet at a time
module mmio_ep_out (
  input  logic                clock,
  input  logic                reset,

  input  logic                set_conf_i,  // Configure, also clears a stall
  input  logic                clr_conf_i,

  input  logic                usb_valid_i,
  output logic                usb_ready_o,
  input  mmio_pkg::usb_beat_t usb_i,

  output logic                cmd_vld_o,   // Held until cmd_ack_i
  output mmio_pkg::mmio_cmd_t cmd_o,
  input  logic                cmd_ack_i,   // Response fully sent

  output logic                ready_o,
  output logic                stalled_o
);

  localparam logic [2:0] LAST_IDX = 3'(`MMIO_CMD_BYTES - 1);

  logic en_q;     // Endpoint configured
  logic stall_q;  // Sticky, framing error seen
  logic pend_q;   // Command waiting for its response
  logic [2:0] cnt_q;
  logic [8*`MMIO_CMD_BYTES-1:0] sh_q;  // Byte 0 ends up in the low byte

  logic xfer_w;
  logic last_w;
  logic bad_w;
  logic good_w;

  assign xfer_w = usb_valid_i && usb_ready_o;
  assign last_w = cnt_q == LAST_IDX;

  // tlast must fall on the last command byte and nowhere else
  assign bad_w  = xfer_w && (usb_i.tlast != last_w);
  assign good_w = xfer_w && last_w && usb_i.tlast && !stall_q;

  // No new bytes while a command is in flight
  assign usb_ready_o = en_q && !pend_q;
  assign ready_o     = en_q && !stall_q;
  assign stalled_o   = stall_q;
  assign cmd_vld_o   = pend_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      en_q <= 1'b0;
    end else if (set_conf_i) begin
      en_q <= 1'b1;
    end else if (clr_conf_i) begin
      en_q <= 1'b0;
    end
  end

  // Stall only clears on a fresh configuration
  always_ff @(posedge clock) begin
    if (reset || set_conf_i) begin
      stall_q <= 1'b0;
    end else if (bad_w) begin
      stall_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clr_conf_i || cmd_ack_i) begin
      pend_q <= 1'b0;
    end else if (good_w) begin
      pend_q <= 1'b1;  // cmd_vld_o the cycle after byte 5
    end
  end

  // Byte position within the packet, restarts on tlast
  always_ff @(posedge clock) begin
    if (reset || set_conf_i || clr_conf_i) begin
      cnt_q <= 3'd0;
    end else if (xfer_w) begin
      if (usb_i.tlast || last_w) begin
        cnt_q <= 3'd0;
      end else begin
        cnt_q <= cnt_q + 3'd1;
      end
    end
  end

  // Shift right, newest byte enters at the top
  always_ff @(posedge clock) begin
    if (xfer_w) begin
      sh_q <= {usb_i.tdata, sh_q[8*`MMIO_CMD_BYTES-1:8]};
    end
  end

  // Field layout of a complete packet
  assign cmd_o.code  = mmio_pkg::cmd_code_e'(sh_q[1:0]);
  assign cmd_o.tag   = sh_q[7:4];    // Upper nibble of byte 0
  assign cmd_o.addr  = sh_q[31:8];   // Bytes 1 to 3
  assign cmd_o.value = sh_q[47:32];  // Bytes 4 and 5

endmodule

// ==== src/mmio_ep_in.sv ====
`timescale 1ns/1ps
`include "mmio_defines.svh"

// Bulk-In endpoint, sends each response as three byte beats
module mmio_ep_in (
  input  logic                clock,
  input  logic                reset,

  input  logic                set_conf_i,
  input  logic                clr_conf_i,

  input  logic                rsp_vld_i,   // Result known this cycle
  input  mmio_pkg::mmio_rsp_t rsp_i,
  output logic                rsp_sent_o,  // Pulse on the tlast beat

  output logic                usb_valid_o,
  input  logic                usb_ready_i,
  output mmio_pkg::usb_beat_t usb_o,

  output logic                ready_o
);

  localparam logic [1:0] LAST_BEAT = 2'(`MMIO_RSP_BYTES - 1);

  logic en_q;
  logic busy_q;  // Response being sent
  logic [1:0] beat_q;
  mmio_pkg::mmio_rsp_t rsp_q;

  logic load_w;
  logic xfer_w;
  logic last_w;

  // Responses are dropped while unconfigured
  assign load_w = rsp_vld_i && en_q && !busy_q;
  assign xfer_w = busy_q && usb_ready_i;
  assign last_w = beat_q == LAST_BEAT;

  assign rsp_sent_o  = xfer_w && last_w;
  assign usb_valid_o = busy_q;
  assign ready_o     = en_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      en_q <= 1'b0;
    end else if (set_conf_i) begin
      en_q <= 1'b1;
    end else if (clr_conf_i) begin
      en_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clr_conf_i) begin
      busy_q <= 1'b0;
      beat_q <= 2'd0;
    end else if (load_w) begin
      busy_q <= 1'b1;  // First byte valid next cycle
      beat_q <= 2'd0;
    end else if (xfer_w) begin
      if (last_w) begin
        busy_q <= 1'b0;
        beat_q <= 2'd0;
      end else begin
        beat_q <= beat_q + 2'd1;  // Beat only advances on a transfer
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load_w) begin
      rsp_q <= rsp_i;
    end
  end

  // Beat mux
  always_comb begin
    case (beat_q)
      2'd0:    usb_o.tdata = {rsp_q.tag, 1'b0, rsp_q.err, rsp_q.code};
      2'd1:    usb_o.tdata = rsp_q.value[7:0];
      default: usb_o.tdata = rsp_q.value[15:8];
    endcase
    usb_o.tkeep = 1'b1;
    usb_o.tlast = last_w;
  end

endmodule

// ==== src/cmd_to_apb.sv ====
`timescale 1ns/1ps

// APB requester, one read or write per start pulse
module cmd_to_apb (
  input  logic                clock,
  input  logic                reset,

  input  logic                start_i,  // Single cycle, GET or SET only
  input  mmio_pkg::mmio_cmd_t cmd_i,

  output mmio_pkg::apb_req_t  apb_o,
  input  mmio_pkg::apb_rsp_t  apb_i,

  output logic                done_o,   // Pulse, results valid with it
  output logic [15:0]         rdata_o,
  output logic                err_o
);

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_SETUP  = 2'd1;
  localparam logic [1:0] S_ACCESS = 2'd2;

  logic [1:0] state_q;
  logic done_q;

  logic [23:0] paddr_q;
  logic        pwrite_q;
  logic [15:0] pwdata_q;
  logic [15:0] rdata_q;
  logic        err_q;

  logic end_w;

  assign end_w = state_q == S_ACCESS && apb_i.pready;  // Last access cycle

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= S_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= end_w;
      case (state_q)
        S_IDLE:   if (start_i) state_q <= S_SETUP;
        S_SETUP:  state_q <= S_ACCESS;  // Setup is always one cycle
        S_ACCESS: if (apb_i.pready) state_q <= S_IDLE;
        default:  state_q <= S_IDLE;
      endcase
    end
  end

  // Address and write data latched at start
  always_ff @(posedge clock) begin
    if (state_q == S_IDLE && start_i) begin
      paddr_q  <= cmd_i.addr;
      pwrite_q <= cmd_i.code == mmio_pkg::SET;
      pwdata_q <= cmd_i.value;
    end
  end

  // Read data and error sampled with pready
  always_ff @(posedge clock) begin
    if (end_w) begin
      rdata_q <= apb_i.prdata;
      err_q   <= apb_i.pslverr;
    end
  end

  assign apb_o.paddr   = paddr_q;
  assign apb_o.pwrite  = pwrite_q;
  assign apb_o.penable = state_q == S_ACCESS;
  assign apb_o.psel    = state_q != S_IDLE;
  assign apb_o.pstrb   = pwrite_q ? 2'b11 : 2'b00;  // Both lanes on writes
  assign apb_o.pwdata  = pwdata_q;

  assign done_o  = done_q;
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

// ==== src/usb_mmio.sv ====
`timescale 1ns/1ps
`include "mmio_defines.svh"

// USB bulk command bridge to APB registers, one command at a time
module usb_mmio (
  input  logic                clock,
  input  logic                reset,

  input  logic                ep_out_set_conf_i,
  input  logic                ep_out_clr_conf_i,
  input  logic                ep_in_set_conf_i,
  input  logic                ep_in_clr_conf_i,
  output logic                ep_out_ready_o,
  output logic                ep_out_stalled_o,
  output logic                ep_in_ready_o,

  // Bulk-Out, commands from host
  input  logic                usb_valid_i,
  output logic                usb_ready_o,
  input  mmio_pkg::usb_beat_t usb_i,

  // Bulk-In, responses to host
  output logic                usb_valid_o,
  input  logic                usb_ready_i,
  output mmio_pkg::usb_beat_t usb_o,

  output mmio_pkg::apb_req_t  apb_o,
  input  mmio_pkg::apb_rsp_t  apb_i
);

  // One-hot states
  localparam logic [3:0] ST_IDLE = 4'b0001;
  localparam logic [3:0] ST_APB  = 4'b0010;
  localparam logic [3:0] ST_RESP = 4'b0100;
  localparam logic [3:0] ST_HALT = 4'b1000;

  logic [3:0] state_q;
  logic start_q;            // Kicks the APB requester
  logic [15:0] done_cnt_q;  // Completed commands, wraps

  mmio_pkg::mmio_cmd_t cmd_w;
  mmio_pkg::mmio_rsp_t rsp_w;
  logic cmd_vld_w;
  logic cmd_ack_w;
  logic out_rdy_w;
  logic in_rdy_w;
  logic en_w;
  logic take_w;
  logic apb_cmd_w;
  logic apb_done_w;
  logic apb_err_w;
  logic [15:0] apb_rdata_w;
  logic rsp_vld_w;
  logic rsp_sent_w;

  assign en_w      = out_rdy_w && in_rdy_w;  // Both pipes usable
  assign take_w    = state_q == ST_IDLE && en_w && cmd_vld_w;
  assign apb_cmd_w = cmd_w.code == mmio_pkg::GET || cmd_w.code == mmio_pkg::SET;

  // Result known: at once for READY/QUERY, at done for APB
  assign rsp_vld_w = (take_w && !apb_cmd_w) || (state_q == ST_APB && en_w && apb_done_w);
  assign cmd_ack_w = state_q == ST_RESP && rsp_sent_w;

  assign ep_out_ready_o = out_rdy_w;
  assign ep_in_ready_o  = in_rdy_w;

  always_ff @(posedge clock) begin
    if (reset || !en_w) begin
      state_q <= ST_HALT;  // Either endpoint lost
    end else begin
      case (state_q)
        ST_HALT: state_q <= ST_IDLE;
        ST_IDLE: if (cmd_vld_w) state_q <= apb_cmd_w ? ST_APB : ST_RESP;
        ST_APB:  if (apb_done_w) state_q <= ST_RESP;
        ST_RESP: if (rsp_sent_w) state_q <= ST_IDLE;
        default: state_q <= ST_HALT;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      start_q    <= 1'b0;
      done_cnt_q <= 16'd0;
    end else begin
      start_q <= take_w && apb_cmd_w;  // psel one cycle after leaving IDLE
      if (cmd_ack_w) begin
        done_cnt_q <= done_cnt_q + 16'd1;
      end
    end
  end

  // Response built from the command and the APB result
  always_comb begin
    rsp_w.tag  = cmd_w.tag;
    rsp_w.code = cmd_w.code;
    rsp_w.err  = 1'b0;
    case (cmd_w.code)
      mmio_pkg::GET: begin
        rsp_w.value = apb_rdata_w;
        rsp_w.err   = apb_err_w;
      end
      mmio_pkg::SET: begin
        rsp_w.value = cmd_w.value;  // Echo of the written word
        rsp_w.err   = apb_err_w;
      end
      mmio_pkg::READY: rsp_w.value = done_cnt_q;  // Excludes this one
      default:         rsp_w.value = `MMIO_DEVICE_ID;
    endcase
  end

  mmio_ep_out u_ep_out (
    .clock       (clock),
    .reset       (reset),
    .set_conf_i  (ep_out_set_conf_i),
    .clr_conf_i  (ep_out_clr_conf_i),
    .usb_valid_i (usb_valid_i),
    .usb_ready_o (usb_ready_o),
    .usb_i       (usb_i),
    .cmd_vld_o   (cmd_vld_w),
    .cmd_o       (cmd_w),
    .cmd_ack_i   (cmd_ack_w),  // Frees the Bulk-Out pipe
    .ready_o     (out_rdy_w),
    .stalled_o   (ep_out_stalled_o)
  );

  mmio_ep_in u_ep_in (
    .clock       (clock),
    .reset       (reset),
    .set_conf_i  (ep_in_set_conf_i),
    .clr_conf_i  (ep_in_clr_conf_i),
    .rsp_vld_i   (rsp_vld_w),
    .rsp_i       (rsp_w),
    .rsp_sent_o  (rsp_sent_w),
    .usb_valid_o (usb_valid_o),
    .usb_ready_i (usb_ready_i),
    .usb_o       (usb_o),
    .ready_o     (in_rdy_w)
  );

  cmd_to_apb u_cmd_to_apb (
    .clock   (clock),
    .reset   (reset),
    .start_i (start_q),
    .cmd_i   (cmd_w),  // Stable while the command is pending
    .apb_o   (apb_o),
    .apb_i   (apb_i),
    .done_o  (apb_done_w),
    .rdata_o (apb_rdata_w),
    .err_o   (apb_err_w)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Free running 40 ns clock, reset high for the first two rising edges
module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  logic clk_q = 1'b0;
  logic rst_q = 1'b1;

  always #20 clk_q = ~clk_q;  // 25 MHz

  initial begin
    repeat (2) @(posedge clk_q);
    rst_q <= 1'b0;
  end

  assign clock_o = clk_q;
  assign reset_o = rst_q;

endmodule

// ==== verif/usb_mmio_sva.sv ====
`timescale 1ns/1ps

// Stream and APB protocol checks bound into usb_mmio
module usb_mmio_sva (
  input logic                clock,
  input logic                reset,
  input logic                in_valid_i,     // Bulk-In side
  input logic                in_ready_i,
  input mmio_pkg::usb_beat_t in_beat_i,
  input logic                out_ready_i,    // Bulk-Out side
  input logic                cmd_pending_i,  // FSM busy with a command
  input mmio_pkg::apb_req_t  apb_req_i
);

  // Beat stays put while the host holds off
  a_beat_hold: assert property (
    @(posedge clock) disable iff (reset)
    in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_beat_i)
  ) else $error("Bulk-In beat changed under back-pressure");

  // Access phase entered only from a setup cycle
  a_setup_first: assert property (
    @(posedge clock) disable iff (reset)
    $rose(apb_req_i.penable) |-> $past(apb_req_i.psel)
  ) else $error("penable rose without a setup cycle");

  // One command in flight
  a_out_blocked: assert property (
    @(posedge clock) disable iff (reset)
    cmd_pending_i |-> !out_ready_i
  ) else $error("Bulk-Out ready while a command is pending");

endmodule

// ==== verif/tb_usb_mmio.sv ====
`timescale 1ns/1ps
`include "mmio_defines.svh"

module tb_usb_mmio;

  // One golden line
  typedef struct packed {
    logic                bad_frame;  // Short packet that must stall Bulk-Out
    mmio_pkg::mmio_cmd_t cmd;
    mmio_pkg::mmio_rsp_t exp;
  } golden_t;

  logic clock;
  logic reset;

  logic                out_set_conf = 1'b0;
  logic                out_clr_conf = 1'b0;
  logic                in_set_conf  = 1'b0;
  logic                in_clr_conf  = 1'b0;
  logic                host_valid   = 1'b0;  // Bulk-Out from host to DUT
  mmio_pkg::usb_beat_t host_beat    = '0;
  logic                dev_ready    = 1'b0;  // Bulk-In back-pressure
  mmio_pkg::apb_rsp_t  apb_rsp      = '0;

  logic                out_ready;
  logic                out_stalled;
  logic                in_ready;
  logic                host_ready;
  logic                dev_valid;
  mmio_pkg::usb_beat_t dev_beat;
  mmio_pkg::apb_req_t  apb_req;

  golden_t             golden_q[$];
  mmio_pkg::mmio_rsp_t rsp_q[$];             // Responses assembled from Bulk-In
  mmio_pkg::mmio_rsp_t rsp_cur;
  mmio_pkg::mmio_cmd_t cur_cmd = '0;         // Command in flight on the bridge
  int                  beat_idx = 0;
  logic [15:0]         mem [logic [23:0]];   // APB target storage
  mmio_pkg::apb_req_t  seen_req = '0;        // APB request of the current cycle
  logic                seen_rdy = 1'b0;
  logic [31:0]         rand_state = 32'he308_8c84;
  logic [1:0]          wait_q = 2'd0;
  logic                answer;
  int                  cycle_count = 0;
  int                  cycle_limit = 1000;

  tb_clock_gen u_clock_gen (
    .clock_o (clock),
    .reset_o (reset)
  );

  usb_mmio dut_i (
    .clock             (clock),
    .reset             (reset),
    .ep_out_set_conf_i (out_set_conf),
    .ep_out_clr_conf_i (out_clr_conf),
    .ep_in_set_conf_i  (in_set_conf),
    .ep_in_clr_conf_i  (in_clr_conf),
    .ep_out_ready_o    (out_ready),
    .ep_out_stalled_o  (out_stalled),
    .ep_in_ready_o     (in_ready),
    .usb_valid_i       (host_valid),
    .usb_ready_o       (host_ready),
    .usb_i             (host_beat),
    .usb_valid_o       (dev_valid),
    .usb_ready_i       (dev_ready),
    .usb_o             (dev_beat),
    .apb_o             (apb_req),
    .apb_i             (apb_rsp)
  );

  bind usb_mmio usb_mmio_sva u_sva (
    .clock         (clock),
    .reset         (reset),
    .in_valid_i    (usb_valid_o),
    .in_ready_i    (usb_ready_i),
    .in_beat_i     (usb_o),
    .out_ready_i   (usb_ready_o),
    .cmd_pending_i (state_q == ST_APB || state_q == ST_RESP),
    .apb_req_i     (apb_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: time %0t signal %s actual %h expected %h",
               $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic read_golden();
    int          fd;
    int          rc;
    string       line;
    logic [3:0]  code;
    logic [3:0]  tag;
    logic [23:0] addr;
    logic [15:0] value;
    logic [15:0] exp_value;
    logic        exp_err;
    golden_t     g;
    fd = $fopen("verif/mmio_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/mmio_golden.txt");
      $display("Test failed");
      $fatal(1, "missing golden file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;  // Blank or column notes
      rc = $sscanf(line, "%h %h %h %h %h %h", code, tag, addr, value, exp_value, exp_err);
      if (rc != 6) begin
        $display("golden line has %0d fields instead of 6: %s", rc, line);
        $display("Test failed");
        $fatal(1, "bad golden file");
      end
      g.bad_frame = code == 4'hf;
      g.cmd.code  = mmio_pkg::cmd_code_e'(code[1:0]);
      g.cmd.tag   = tag;
      g.cmd.addr  = addr;
      g.cmd.value = value;
      g.exp.tag   = tag;        // Echoed
      g.exp.code  = code[1:0];  // Echoed
      g.exp.err   = exp_err;
      g.exp.value = exp_value;
      golden_q.push_back(g);
    end
    $fclose(fd);
  endtask

  // Called just after a rising edge, returns on the edge where the byte transfers
  task automatic send_beat(input logic [7:0] data, input logic last);
    host_beat  <= '{tdata: data, tkeep: 1'b1, tlast: last};
    host_valid <= 1'b1;
    @(negedge clock);
    while (!host_ready) begin
      @(negedge clock);
    end
    @(posedge clock);
  endtask

  // tlast goes on byte nbytes-1, so 4 gives a framing error
  task automatic send_packet(input mmio_pkg::mmio_cmd_t cmd, input int nbytes);
    logic [7:0] bytes [`MMIO_CMD_BYTES];
    bytes[0] = {cmd.tag, 2'b00, cmd.code};
    bytes[1] = cmd.addr[7:0];    // LSB first
    bytes[2] = cmd.addr[15:8];
    bytes[3] = cmd.addr[23:16];
    bytes[4] = cmd.value[7:0];
    bytes[5] = cmd.value[15:8];
    @(posedge clock);
    for (int i = 0; i < nbytes; i++) begin
      send_beat(bytes[i], i == nbytes - 1);
    end
    host_valid <= 1'b0;
  endtask

  task automatic configure(input logic out_ep, input logic in_ep);
    @(posedge clock);
    out_set_conf <= out_ep;
    in_set_conf  <= in_ep;
    @(posedge clock);
    out_set_conf <= 1'b0;
    in_set_conf  <= 1'b0;
    @(negedge clock);  // Enables visible here
  endtask

  task automatic run_command(input golden_t g);
    mmio_pkg::mmio_rsp_t got;
    cur_cmd = g.cmd;
    send_packet(g.cmd, `MMIO_CMD_BYTES);
    while (rsp_q.size() == 0) begin
      @(negedge clock);
    end
    got = rsp_q.pop_front();
    check("rsp tag", 32'(got.tag), 32'(g.exp.tag));
    check("rsp code", 32'(got.code), 32'(g.exp.code));
    check("rsp err", 32'(got.err), 32'(g.exp.err));
    check("rsp value", 32'(got.value), 32'(g.exp.value));
  endtask

  task automatic run_bad_frame(input golden_t g);
    send_packet(g.cmd, 4);
    @(negedge clock);
    check("ep_out_stalled_o", 32'(out_stalled), 32'd1);
    check("ep_out_ready_o", 32'(out_ready), 32'd0);
    repeat (20) @(negedge clock);  // Bulk-In stays quiet for a dropped packet
    check("bulk-in responses", 32'(rsp_q.size()), 32'd0);
    check("usb_valid_o", 32'(dev_valid), 32'd0);
    configure(1'b1, 1'b0);  // Reconfigure clears the stall
    check("ep_out_stalled_o", 32'(out_stalled), 32'd0);
    check("ep_out_ready_o", 32'(out_ready), 32'd1);
  endtask

  // Bulk-In monitor sampling mid-cycle
  always @(negedge clock) begin
    seen_req = apb_req;
    seen_rdy = apb_rsp.pready;
    if (!reset && dev_valid && dev_ready) begin  // Transfers on the next edge
      check("usb_o.tkeep", 32'(dev_beat.tkeep), 32'd1);
      check("usb_o.tlast", 32'(dev_beat.tlast), 32'(beat_idx == 2));
      case (beat_idx)
        0: begin
          check("usb_o.tdata[3]", 32'(dev_beat.tdata[3]), 32'd0);
          rsp_cur.tag  = dev_beat.tdata[7:4];
          rsp_cur.err  = dev_beat.tdata[2];
          rsp_cur.code = dev_beat.tdata[1:0];
        end
        1:       rsp_cur.value[7:0]  = dev_beat.tdata;
        default: rsp_cur.value[15:8] = dev_beat.tdata;
      endcase
      if (beat_idx == 2) begin
        rsp_q.push_back(rsp_cur);
        beat_idx = 0;
      end else begin
        beat_idx++;
      end
    end
  end

  // APB target with random wait states, plus Bulk-In back-pressure
  always @(posedge clock) begin
    rand_state = lcg_next(rand_state);
    answer     = 1'b0;
    dev_ready      <= rand_state[20];
    apb_rsp.pready <= 1'b0;
    if (seen_req.psel && !seen_req.penable) begin
      wait_q = rand_state[25:24];  // 0 to 3 wait states
      answer = wait_q == 2'd0;
    end else if (seen_req.psel && !seen_rdy) begin
      wait_q = wait_q - 2'd1;
      answer = wait_q == 2'd0;
    end
    if (answer) begin
      // GET reads and SET writes at the command address
      check("apb_o.paddr", 32'(seen_req.paddr), 32'(cur_cmd.addr));
      check("apb_o.pwrite", 32'(seen_req.pwrite), 32'(cur_cmd.code == mmio_pkg::SET));
      apb_rsp.pready  <= 1'b1;
      apb_rsp.pslverr <= seen_req.paddr[23];  // Upper half of the map faults
      if (!seen_req.paddr[23] && mem.exists(seen_req.paddr)) begin
        apb_rsp.prdata <= mem[seen_req.paddr];
      end else begin
        apb_rsp.prdata <= 16'h0000;
      end
      if (seen_req.pwrite && !seen_req.paddr[23]) begin
        check("apb_o.pstrb", 32'(seen_req.pstrb), 32'd3);
        mem[seen_req.paddr] = seen_req.pwdata;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout, the run passed its limit of %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1, "watchdog expired");
    end
  end

  initial begin
    read_golden();
    cycle_limit = 200 * (golden_q.size() + 1);
    @(negedge clock);
    while (reset) begin
      @(negedge clock);
    end
    // Nothing may move while unconfigured
    repeat (6) begin
      @(negedge clock);
      check("usb_ready_o", 32'(host_ready), 32'd0);
      check("apb_o.psel", 32'(apb_req.psel), 32'd0);
    end
    configure(1'b1, 1'b1);
    check("ep_out_ready_o", 32'(out_ready), 32'd1);
    check("ep_in_ready_o", 32'(in_ready), 32'd1);
    foreach (golden_q[i]) begin
      if (golden_q[i].bad_frame) begin
        run_bad_frame(golden_q[i]);
      end else begin
        run_command(golden_q[i]);
      end
    end
    repeat (10) @(negedge clock);
    if (rsp_q.size() != 0) begin
      $display("%0d responses arrived that no command asked for", rsp_q.size());
      $display("Test failed");
      $fatal(1, "extra responses");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
+incdir+include
src/mmio_pkg.sv
src/mmio_ep_out.sv
src/mmio_ep_in.sv
src/cmd_to_apb.sv
src/usb_mmio.sv
verif/tb_clock_gen.sv
verif/usb_mmio_sva.sv
verif/tb_usb_mmio.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the USB to APB bridge testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_usb_mmio -f sim.f

# A fatal stop exits non-zero, the pass line below decides the result
output=$(./obj_dir/Vtb_usb_mmio 2>&1) || true
echo "$output"

if grep -q "Test completed successfully" <<< "$output"; then
  exit 0
fi
exit 1

// ==== verif/mmio_golden.txt ====
# code tag addr value exp_value exp_err, all hex, one command per line
# code f sends a 4-byte packet ending in tlast, expects a stall and no response
3 1 000000 0000 b51c 0
2 2 000000 0000 0001 0
1 3 000010 a5c3 a5c3 0
0 4 000010 0000 a5c3 0
1 5 001234 0f0f 0f0f 0
1 6 800004 1111 1111 1
0 7 800004 0000 0000 1
0 8 000020 0000 0000 0
2 9 000000 0000 0008 0
f a 00beef 0000 0000 0
3 a 000000 0000 b51c 0
0 b 001234 0000 0f0f 0
1 c 000010 7e81 7e81 0
0 d 000010 0000 7e81 0
2 e 000000 0000 000d 0
0 f 00ffff 0000 0000 0
